// File: verilog/exec_pkg.sv
package exec_pkg;

  // datapath width
  localparam int XLEN = 32;
  // pc counts words, low two byte bits dropped
  localparam int PC_W = XLEN - 2;
  // reorder buffer id
  localparam int ROB_W = 6;
  // physical register tag, tag 0 reads as zero
  localparam int PREG_W = 6;

  // opcode class of an issued micro-op
  typedef enum logic [2:0] {
    CLS_ALU    = 3'd0,
    CLS_BRANCH = 3'd1,
    CLS_JAL    = 3'd2,
    CLS_JALR   = 3'd3,
    CLS_LUI    = 3'd4,
    CLS_AUIPC  = 3'd5
  } uop_class_e;

  // alu operation, the last five are zbb
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9,
    ALU_MIN  = 4'd10,
    ALU_MAX  = 4'd11,
    ALU_MINU = 4'd12,
    ALU_MAXU = 4'd13,
    ALU_ANDN = 4'd14
  } alu_op_e;

  // conditional branch compare
  typedef enum logic [2:0] {
    BR_EQ  = 3'd0,
    BR_NE  = 3'd1,
    BR_LT  = 3'd2,
    BR_GE  = 3'd3,
    BR_LTU = 3'd4,
    BR_GEU = 3'd5
  } br_cond_e;

endpackage

// File: verilog/phys_regfile.sv
module phys_regfile #(
  parameter int NUM_PREGS = 64
) (
  input  logic                       core_clock_i,
  input  logic                       rst_n_i,
  input  logic [exec_pkg::PREG_W-1:0] rd0_tag_i,
  input  logic [exec_pkg::PREG_W-1:0] rd1_tag_i,
  input  logic                       wr_en_i,
  input  logic [exec_pkg::PREG_W-1:0] wr_tag_i,
  input  logic [exec_pkg::XLEN-1:0]   wr_data_i,
  output logic [exec_pkg::XLEN-1:0]   rd0_data_o,
  output logic [exec_pkg::XLEN-1:0]   rd1_data_o
);
  import exec_pkg::*;

  logic [XLEN-1:0] regs [NUM_PREGS];
  logic            rd0_hit;
  logic            rd1_hit;
  logic            wr_hit;

  // tag 0 and tags past the array read as zero
  assign rd0_hit = (rd0_tag_i != '0) && (int'(rd0_tag_i) < NUM_PREGS);
  assign rd1_hit = (rd1_tag_i != '0) && (int'(rd1_tag_i) < NUM_PREGS);
  assign wr_hit  = wr_en_i && (wr_tag_i != '0) && (int'(wr_tag_i) < NUM_PREGS);

  // async reads, same-cycle write not visible here
  assign rd0_data_o = rd0_hit ? regs[rd0_tag_i] : '0;
  assign rd1_data_o = rd1_hit ? regs[rd1_tag_i] : '0;

  always_ff @(posedge core_clock_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NUM_PREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_hit) begin
      regs[wr_tag_i] <= wr_data_i;
    end
  end

  // pipe must filter zero-tag writes before they get here
  a_no_zero_write : assert property (
    @(posedge core_clock_i) disable iff (!rst_n_i)
    wr_en_i |-> (wr_tag_i != '0)
  );

endmodule

// File: verilog/operand_stage.sv
module operand_stage (
  input  logic                        core_clock_i,
  input  logic                        rst_n_i,
  input  logic [exec_pkg::PREG_W-1:0] issue_rs1_i,
  input  logic [exec_pkg::PREG_W-1:0] issue_rs2_i,
  input  exec_pkg::uop_class_e        issue_class_i,
  input  exec_pkg::alu_op_e           issue_alu_op_i,
  input  exec_pkg::br_cond_e          issue_cond_i,
  input  logic                        issue_use_imm_i,
  input  logic [exec_pkg::XLEN-1:0]   issue_imm_i,
  input  logic [exec_pkg::PC_W-1:0]   issue_pc_i,
  input  logic                        pred_taken_i,
  input  logic [exec_pkg::PC_W-1:0]   pred_target_i,
  input  logic [exec_pkg::XLEN-1:0]   rd0_data_i,
  input  logic [exec_pkg::XLEN-1:0]   rd1_data_i,
  input  logic                        ex_valid_i,
  input  logic [exec_pkg::PREG_W-1:0] ex_dest_i,
  input  logic [exec_pkg::XLEN-1:0]   ex_data_i,
  output logic [exec_pkg::XLEN-1:0]   op_a_o,
  output logic [exec_pkg::XLEN-1:0]   op_b_o,
  output logic [exec_pkg::XLEN-1:0]   offset_o,
  output logic [exec_pkg::PC_W-1:0]   pc_o,
  output exec_pkg::uop_class_e        class_o,
  output exec_pkg::alu_op_e           alu_op_o,
  output exec_pkg::br_cond_e          cond_o,
  output logic                        pred_taken_o,
  output logic [exec_pkg::PC_W-1:0]   pred_target_o
);
  import exec_pkg::*;

  logic [XLEN-1:0] rs1_val;
  logic [XLEN-1:0] rs2_val;
  logic [XLEN-1:0] op_a_d;
  logic [XLEN-1:0] op_b_d;
  alu_op_e         alu_op_d;

  // bypass from execute, tag 0 never forwarded
  assign rs1_val = (ex_valid_i && (ex_dest_i == issue_rs1_i) && (issue_rs1_i != '0))
                   ? ex_data_i : rd0_data_i;
  assign rs2_val = (ex_valid_i && (ex_dest_i == issue_rs2_i) && (issue_rs2_i != '0))
                   ? ex_data_i : rd1_data_i;

  always_comb begin
    // operand a: zero, byte pc or rs1
    if (issue_class_i == CLS_LUI) begin
      op_a_d = '0;
    end else if ((issue_class_i == CLS_AUIPC) || (issue_class_i == CLS_JAL)) begin
      op_a_d = {issue_pc_i, 2'b00};
    end else begin
      op_a_d = rs1_val;
    end
    // operand b: immediate or rs2
    if (issue_use_imm_i || (issue_class_i == CLS_LUI) || (issue_class_i == CLS_AUIPC)) begin
      op_b_d = issue_imm_i;
    end else begin
      op_b_d = rs2_val;
    end
    // lui and auipc take the adder output
    if ((issue_class_i == CLS_LUI) || (issue_class_i == CLS_AUIPC)) begin
      alu_op_d = ALU_ADD;
    end else begin
      alu_op_d = issue_alu_op_i;
    end
  end

  // decode state into execute
  always_ff @(posedge core_clock_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      class_o      <= CLS_ALU;
      pred_taken_o <= 1'b0;
    end else begin
      class_o      <= issue_class_i;
      pred_taken_o <= pred_taken_i;
    end
  end

  // operand payload
  always_ff @(posedge core_clock_i) begin
    op_a_o        <= op_a_d;
    op_b_o        <= op_b_d;
    offset_o      <= issue_imm_i;
    pc_o          <= issue_pc_i;
    alu_op_o      <= alu_op_d;
    cond_o        <= issue_cond_i;
    pred_target_o <= pred_target_i;
  end

endmodule

// File: verilog/int_alu.sv
module int_alu #(
  parameter bit HAS_ZBB = 1'b1
) (
  input  logic [exec_pkg::XLEN-1:0] a_i,
  input  logic [exec_pkg::XLEN-1:0] b_i,
  input  exec_pkg::alu_op_e         op_i,
  output logic [exec_pkg::XLEN-1:0] result_o,
  output logic                      lt_signed_o,
  output logic                      lt_unsigned_o,
  output logic                      eq_o
);
  import exec_pkg::*;

  localparam int SHAMT_W = $clog2(XLEN);

  logic [XLEN-1:0]    sum;
  logic [XLEN-1:0]    diff;
  logic [SHAMT_W-1:0] shamt;
  logic [XLEN-1:0]    min_s;
  logic [XLEN-1:0]    max_s;
  logic [XLEN-1:0]    min_u;
  logic [XLEN-1:0]    max_u;

  assign sum   = a_i + b_i;
  assign diff  = a_i - b_i;
  assign shamt = b_i[SHAMT_W-1:0];

  // compare flags, shared with branch resolve
  assign lt_signed_o   = $signed(a_i) < $signed(b_i);
  assign lt_unsigned_o = a_i < b_i;
  assign eq_o          = a_i == b_i;

  // zbb min/max built on the flags
  assign min_s = lt_signed_o ? a_i : b_i;
  assign max_s = lt_signed_o ? b_i : a_i;
  assign min_u = lt_unsigned_o ? a_i : b_i;
  assign max_u = lt_unsigned_o ? b_i : a_i;

  always_comb begin
    case (op_i)
      ALU_ADD:  result_o = sum;
      ALU_SUB:  result_o = diff;
      ALU_AND:  result_o = a_i & b_i;
      ALU_OR:   result_o = a_i | b_i;
      ALU_XOR:  result_o = a_i ^ b_i;
      ALU_SLL:  result_o = a_i << shamt;
      ALU_SRL:  result_o = a_i >> shamt;
      // arithmetic shift keeps the sign
      ALU_SRA:  result_o = XLEN'($signed(a_i) >>> shamt);
      ALU_SLT:  result_o = XLEN'(lt_signed_o);
      ALU_SLTU: result_o = XLEN'(lt_unsigned_o);
      // zbb ops read zero when not built
      ALU_MIN:  result_o = HAS_ZBB ? min_s : '0;
      ALU_MAX:  result_o = HAS_ZBB ? max_s : '0;
      ALU_MINU: result_o = HAS_ZBB ? min_u : '0;
      ALU_MAXU: result_o = HAS_ZBB ? max_u : '0;
      ALU_ANDN: result_o = HAS_ZBB ? (a_i & ~b_i) : '0;
      default:  result_o = '0;
    endcase
  end

endmodule

// File: verilog/branch_resolve.sv
module branch_resolve (
  input  exec_pkg::uop_class_e      class_i,
  input  exec_pkg::br_cond_e        cond_i,
  input  logic [exec_pkg::XLEN-1:0] rs1_i,
  input  logic [exec_pkg::XLEN-1:0] offset_i,
  input  logic [exec_pkg::PC_W-1:0] pc_i,
  input  logic                      pred_taken_i,
  input  logic [exec_pkg::PC_W-1:0] pred_target_i,
  input  logic                      lt_signed_i,
  input  logic                      lt_unsigned_i,
  input  logic                      eq_i,
  output logic [exec_pkg::XLEN-1:0] link_o,
  output logic                      taken_o,
  output logic [exec_pkg::PC_W-1:0] target_o,
  output logic                      mispredict_o
);
  import exec_pkg::*;

  logic            cond_true;
  logic            is_ctrl;
  logic [XLEN-1:0] jalr_sum;
  logic [PC_W-1:0] pc_next;

  // condition from the alu compare flags
  always_comb begin
    case (cond_i)
      BR_EQ:   cond_true = eq_i;
      BR_NE:   cond_true = !eq_i;
      BR_LT:   cond_true = lt_signed_i;
      BR_GE:   cond_true = !lt_signed_i;
      BR_LTU:  cond_true = lt_unsigned_i;
      BR_GEU:  cond_true = !lt_unsigned_i;
      default: cond_true = 1'b0;
    endcase
  end

  assign is_ctrl = (class_i == CLS_BRANCH) || (class_i == CLS_JAL) || (class_i == CLS_JALR);

  // jumps always taken, other classes never
  always_comb begin
    case (class_i)
      CLS_BRANCH: taken_o = cond_true;
      CLS_JAL:    taken_o = 1'b1;
      CLS_JALR:   taken_o = 1'b1;
      default:    taken_o = 1'b0;
    endcase
  end

  // jalr target is a byte address, word part kept
  assign jalr_sum = rs1_i + offset_i;
  assign target_o = (class_i == CLS_JALR) ? jalr_sum[PC_W+1:2]
                                          : pc_i + offset_i[PC_W+1:2];

  // return address one word on
  assign pc_next = pc_i + PC_W'(1);
  assign link_o  = {pc_next, 2'b00};

  // wrong direction, or right direction with wrong target
  assign mispredict_o = is_ctrl &&
                        ((taken_o != pred_taken_i) ||
                         (taken_o && pred_taken_i && (target_o != pred_target_i)));

endmodule

// File: verilog/simple_pipe.sv
module simple_pipe #(
  parameter bit HAS_ZBB = 1'b1
) (
  input  logic                        core_clock_i,
  input  logic                        rst_n_i,
  input  logic                        issue_valid_i,
  input  logic [exec_pkg::PREG_W-1:0] issue_rs1_i,
  input  logic [exec_pkg::PREG_W-1:0] issue_rs2_i,
  input  logic [exec_pkg::PREG_W-1:0] issue_dest_i,
  input  logic [exec_pkg::ROB_W-1:0]  issue_rob_i,
  input  exec_pkg::uop_class_e        issue_class_i,
  input  exec_pkg::alu_op_e           issue_alu_op_i,
  input  exec_pkg::br_cond_e          issue_cond_i,
  input  logic                        issue_use_imm_i,
  input  logic [exec_pkg::XLEN-1:0]   issue_imm_i,
  input  logic [exec_pkg::PC_W-1:0]   issue_pc_i,
  input  logic                        pred_taken_i,
  input  logic [exec_pkg::PC_W-1:0]   pred_target_i,
  output logic [exec_pkg::PREG_W-1:0] rd0_tag_o,
  output logic [exec_pkg::PREG_W-1:0] rd1_tag_o,
  input  logic [exec_pkg::XLEN-1:0]   rd0_data_i,
  input  logic [exec_pkg::XLEN-1:0]   rd1_data_i,
  output logic                        wb_en_o,
  output logic [exec_pkg::PREG_W-1:0] wb_dest_o,
  output logic [exec_pkg::XLEN-1:0]   wb_data_o,
  output logic                        result_valid_o,
  output logic [exec_pkg::ROB_W-1:0]  result_rob_o,
  output logic [exec_pkg::PREG_W-1:0] result_dest_o,
  output logic [exec_pkg::XLEN-1:0]   result_data_o,
  output logic                        redirect_valid_o,
  output logic [exec_pkg::PC_W-1:0]   redirect_pc_o
);
  import exec_pkg::*;

  // execute stage state
  logic               ex_valid_q;
  logic [ROB_W-1:0]   ex_rob_q;
  logic [PREG_W-1:0]  ex_dest_q;

  // operand stage outputs
  logic [XLEN-1:0]    ex_a;
  logic [XLEN-1:0]    ex_b;
  logic [XLEN-1:0]    ex_offset;
  logic [PC_W-1:0]    ex_pc;
  uop_class_e         ex_class;
  alu_op_e            ex_alu_op;
  br_cond_e           ex_cond;
  logic               ex_pred_taken;
  logic [PC_W-1:0]    ex_pred_target;

  // execute results
  logic [XLEN-1:0]    alu_result;
  logic               lt_s;
  logic               lt_u;
  logic               eq;
  logic [XLEN-1:0]    br_link;
  logic               br_taken;
  logic [PC_W-1:0]    br_target;
  logic               br_mispredict;
  logic [XLEN-1:0]    ex_result;
  logic               is_link;
  logic               class_writes;

  // register file read straight from the issue tags
  assign rd0_tag_o = issue_rs1_i;
  assign rd1_tag_o = issue_rs2_i;

  always_ff @(posedge core_clock_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ex_valid_q <= 1'b0;
    end else begin
      ex_valid_q <= issue_valid_i;
    end
  end

  always_ff @(posedge core_clock_i) begin
    ex_rob_q  <= issue_rob_i;
    ex_dest_q <= issue_dest_i;
  end

  operand_stage operand_stage_i (
    .core_clock_i   (core_clock_i),
    .rst_n_i        (rst_n_i),
    .issue_rs1_i    (issue_rs1_i),
    .issue_rs2_i    (issue_rs2_i),
    .issue_class_i  (issue_class_i),
    .issue_alu_op_i (issue_alu_op_i),
    .issue_cond_i   (issue_cond_i),
    .issue_use_imm_i(issue_use_imm_i),
    .issue_imm_i    (issue_imm_i),
    .issue_pc_i     (issue_pc_i),
    .pred_taken_i   (pred_taken_i),
    .pred_target_i  (pred_target_i),
    .rd0_data_i     (rd0_data_i),
    .rd1_data_i     (rd1_data_i),
    .ex_valid_i     (wb_en_o),
    .ex_dest_i      (ex_dest_q),
    .ex_data_i      (ex_result),
    .op_a_o         (ex_a),
    .op_b_o         (ex_b),
    .offset_o       (ex_offset),
    .pc_o           (ex_pc),
    .class_o        (ex_class),
    .alu_op_o       (ex_alu_op),
    .cond_o         (ex_cond),
    .pred_taken_o   (ex_pred_taken),
    .pred_target_o  (ex_pred_target)
  );

  int_alu #(
    .HAS_ZBB(HAS_ZBB)
  ) int_alu_i (
    .a_i          (ex_a),
    .b_i          (ex_b),
    .op_i         (ex_alu_op),
    .result_o     (alu_result),
    .lt_signed_o  (lt_s),
    .lt_unsigned_o(lt_u),
    .eq_o         (eq)
  );

  branch_resolve branch_resolve_i (
    .class_i      (ex_class),
    .cond_i       (ex_cond),
    .rs1_i        (ex_a),
    .offset_i     (ex_offset),
    .pc_i         (ex_pc),
    .pred_taken_i (ex_pred_taken),
    .pred_target_i(ex_pred_target),
    .lt_signed_i  (lt_s),
    .lt_unsigned_i(lt_u),
    .eq_i         (eq),
    .link_o       (br_link),
    .taken_o      (br_taken),
    .target_o     (br_target),
    .mispredict_o (br_mispredict)
  );

  // jumps return the link, lui/auipc already forced to add
  assign is_link      = (ex_class == CLS_JAL) || (ex_class == CLS_JALR);
  assign ex_result    = is_link ? br_link : alu_result;
  assign class_writes = ex_class != CLS_BRANCH;

  // writeback doubles as the bypass source
  assign wb_en_o   = ex_valid_q && class_writes && (ex_dest_q != '0);
  assign wb_dest_o = ex_dest_q;
  assign wb_data_o = ex_result;

  assign result_valid_o = ex_valid_q;
  assign result_rob_o   = ex_rob_q;
  assign result_dest_o  = ex_dest_q;
  assign result_data_o  = ex_result;

  // not taken falls through to the link word
  assign redirect_valid_o = ex_valid_q && br_mispredict;
  assign redirect_pc_o    = br_taken ? br_target : br_link[XLEN-1:2];

  a_redirect_ctrl : assert property (
    @(posedge core_clock_i) disable iff (!rst_n_i)
    redirect_valid_o |->
      (ex_class inside {CLS_BRANCH, CLS_JAL, CLS_JALR})
  );

  // nothing completes on the first edge out of reset
  a_quiet_after_reset : assert property (
    @(posedge core_clock_i)
    $rose(rst_n_i) |-> !result_valid_o
  );

endmodule

// File: verilog/exec_top.sv
module exec_top #(
  parameter bit HAS_ZBB   = 1'b1,
  parameter int NUM_PREGS = 64
) (
  input  logic                        core_clock_i,
  input  logic                        rst_n_i,
  input  logic                        issue_valid_i,
  input  logic [exec_pkg::PREG_W-1:0] issue_rs1_i,
  input  logic [exec_pkg::PREG_W-1:0] issue_rs2_i,
  input  logic [exec_pkg::PREG_W-1:0] issue_dest_i,
  input  logic [exec_pkg::ROB_W-1:0]  issue_rob_i,
  input  exec_pkg::uop_class_e        issue_class_i,
  input  exec_pkg::alu_op_e           issue_alu_op_i,
  input  exec_pkg::br_cond_e          issue_cond_i,
  input  logic                        issue_use_imm_i,
  input  logic [exec_pkg::XLEN-1:0]   issue_imm_i,
  input  logic [exec_pkg::PC_W-1:0]   issue_pc_i,
  input  logic                        pred_taken_i,
  input  logic [exec_pkg::PC_W-1:0]   pred_target_i,
  output logic                        result_valid_o,
  output logic [exec_pkg::ROB_W-1:0]  result_rob_o,
  output logic [exec_pkg::PREG_W-1:0] result_dest_o,
  output logic [exec_pkg::XLEN-1:0]   result_data_o,
  output logic                        redirect_valid_o,
  output logic [exec_pkg::PC_W-1:0]   redirect_pc_o
);
  import exec_pkg::*;

  // register file read and write paths
  logic [PREG_W-1:0] rd0_tag;
  logic [PREG_W-1:0] rd1_tag;
  logic [XLEN-1:0]   rd0_data;
  logic [XLEN-1:0]   rd1_data;
  logic              wb_en;
  logic [PREG_W-1:0] wb_dest;
  logic [XLEN-1:0]   wb_data;

  phys_regfile #(
    .NUM_PREGS(NUM_PREGS)
  ) phys_regfile_i (
    .core_clock_i(core_clock_i),
    .rst_n_i     (rst_n_i),
    .rd0_tag_i   (rd0_tag),
    .rd1_tag_i   (rd1_tag),
    .wr_en_i     (wb_en),
    .wr_tag_i    (wb_dest),
    .wr_data_i   (wb_data),
    .rd0_data_o  (rd0_data),
    .rd1_data_o  (rd1_data)
  );

  simple_pipe #(
    .HAS_ZBB(HAS_ZBB)
  ) simple_pipe_i (
    .core_clock_i    (core_clock_i),
    .rst_n_i         (rst_n_i),
    .issue_valid_i   (issue_valid_i),
    .issue_rs1_i     (issue_rs1_i),
    .issue_rs2_i     (issue_rs2_i),
    .issue_dest_i    (issue_dest_i),
    .issue_rob_i     (issue_rob_i),
    .issue_class_i   (issue_class_i),
    .issue_alu_op_i  (issue_alu_op_i),
    .issue_cond_i    (issue_cond_i),
    .issue_use_imm_i (issue_use_imm_i),
    .issue_imm_i     (issue_imm_i),
    .issue_pc_i      (issue_pc_i),
    .pred_taken_i    (pred_taken_i),
    .pred_target_i   (pred_target_i),
    .rd0_tag_o       (rd0_tag),
    .rd1_tag_o       (rd1_tag),
    .rd0_data_i      (rd0_data),
    .rd1_data_i      (rd1_data),
    .wb_en_o         (wb_en),
    .wb_dest_o       (wb_dest),
    .wb_data_o       (wb_data),
    .result_valid_o  (result_valid_o),
    .result_rob_o    (result_rob_o),
    .result_dest_o   (result_dest_o),
    .result_data_o   (result_data_o),
    .redirect_valid_o(redirect_valid_o),
    .redirect_pc_o   (redirect_pc_o)
  );

endmodule

// File: tests/tb_ref.svh
`ifndef TB_REF_SVH
`define TB_REF_SVH

// dut build options, also handed to the instance
localparam bit TB_HAS_ZBB   = 1'b1;
localparam int TB_NUM_PREGS = 64;
localparam int CLK_PERIOD   = 8;
localparam int RESET_CYCLES = 16;
// micro-ops per test phase
localparam int SWEEP_UOPS   = 64;
localparam int FILL_UOPS    = 63;
localparam int ALU_UOPS     = 30;
localparam int CHAIN_UOPS   = 16;
localparam int SPECIAL_UOPS = 6;
localparam int BRANCH_UOPS  = 24;
localparam int RANDOM_UOPS  = 300;
localparam int TOTAL_UOPS   = SWEEP_UOPS + FILL_UOPS + ALU_UOPS + CHAIN_UOPS +
                              SPECIAL_UOPS + BRANCH_UOPS + RANDOM_UOPS;

// shadow of the physical registers, updated in issue order
logic [XLEN-1:0] shadow_regs [TB_NUM_PREGS];

// one expected completion
typedef struct packed {
  logic [ROB_W-1:0]  rob;
  logic [PREG_W-1:0] dest;
  logic [XLEN-1:0]   data;
  logic              redir;
  logic [PC_W-1:0]   redir_pc;
} expect_t;

function automatic logic [XLEN-1:0] ref_alu(input alu_op_e op, input logic [XLEN-1:0] a,
                                            input logic [XLEN-1:0] b);
  logic [4:0]      sh;
  logic            lts;
  logic            ltu;
  logic [XLEN-1:0] sign_fill;
  logic [XLEN-1:0] r;
  sh  = b[4:0];
  lts = $signed(a) < $signed(b);
  ltu = a < b;
  // ones shifted in from the top for a negative sra
  sign_fill = a[XLEN-1] ? ~({XLEN{1'b1}} >> sh) : '0;
  case (op)
    ALU_ADD:  r = a + b;
    ALU_SUB:  r = a - b;
    ALU_AND:  r = a & b;
    ALU_OR:   r = a | b;
    ALU_XOR:  r = a ^ b;
    ALU_SLL:  r = a << sh;
    ALU_SRL:  r = a >> sh;
    ALU_SRA:  r = (a >> sh) | sign_fill;
    ALU_SLT:  r = {{(XLEN-1){1'b0}}, lts};
    ALU_SLTU: r = {{(XLEN-1){1'b0}}, ltu};
    // zbb group, zero without the extension
    ALU_MIN:  r = TB_HAS_ZBB ? (lts ? a : b) : '0;
    ALU_MAX:  r = TB_HAS_ZBB ? (lts ? b : a) : '0;
    ALU_MINU: r = TB_HAS_ZBB ? (ltu ? a : b) : '0;
    ALU_MAXU: r = TB_HAS_ZBB ? (ltu ? b : a) : '0;
    ALU_ANDN: r = TB_HAS_ZBB ? (a & ~b) : '0;
    default:  r = '0;
  endcase
  return r;
endfunction

// taken decision, jumps always taken
function automatic logic ref_branch(input uop_class_e cls, input br_cond_e cond,
                                    input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
  logic t;
  case (cond)
    BR_EQ:   t = (a == b);
    BR_NE:   t = (a != b);
    BR_LT:   t = ($signed(a) < $signed(b));
    BR_GE:   t = ($signed(a) >= $signed(b));
    BR_LTU:  t = (a < b);
    BR_GEU:  t = (a >= b);
    default: t = 1'b0;
  endcase
  if ((cls == CLS_JAL) || (cls == CLS_JALR)) begin
    t = 1'b1;
  end else if (cls != CLS_BRANCH) begin
    t = 1'b0;
  end
  return t;
endfunction

// word target, imm is a byte offset
function automatic logic [PC_W-1:0] ref_target(input uop_class_e cls,
                                               input logic [XLEN-1:0] rs1,
                                               input logic [XLEN-1:0] imm,
                                               input logic [PC_W-1:0] pc);
  logic [XLEN-1:0] sum;
  sum = rs1 + imm;
  if (cls == CLS_JALR) begin
    return sum[XLEN-1:2];
  end
  return pc + imm[XLEN-1:2];
endfunction

// {redirect, next pc}
function automatic logic [PC_W:0] ref_redirect(input uop_class_e cls, input logic taken,
                                               input logic [PC_W-1:0] target,
                                               input logic [PC_W-1:0] pc,
                                               input logic pred_taken,
                                               input logic [PC_W-1:0] pred_target);
  logic            ctrl;
  logic            wrong;
  logic [PC_W-1:0] next_pc;
  ctrl    = (cls == CLS_BRANCH) || (cls == CLS_JAL) || (cls == CLS_JALR);
  wrong   = (taken != pred_taken) || (taken && (target != pred_target));
  next_pc = taken ? target : pc + PC_W'(1);
  return {ctrl && wrong, next_pc};
endfunction

`endif

// File: tests/tb_exec_top.sv
module tb_exec_top;
  import exec_pkg::*;

  `include "tb_ref.svh"

  logic              core_clock_i = 1'b0;
  logic              rst_n_i;
  logic              issue_valid_i;
  logic [PREG_W-1:0] issue_rs1_i;
  logic [PREG_W-1:0] issue_rs2_i;
  logic [PREG_W-1:0] issue_dest_i;
  logic [ROB_W-1:0]  issue_rob_i;
  uop_class_e        issue_class_i;
  alu_op_e           issue_alu_op_i;
  br_cond_e          issue_cond_i;
  logic              issue_use_imm_i;
  logic [XLEN-1:0]   issue_imm_i;
  logic [PC_W-1:0]   issue_pc_i;
  logic              pred_taken_i;
  logic [PC_W-1:0]   pred_target_i;
  logic              result_valid_o;
  logic [ROB_W-1:0]  result_rob_o;
  logic [PREG_W-1:0] result_dest_o;
  logic [XLEN-1:0]   result_data_o;
  logic              redirect_valid_o;
  logic [PC_W-1:0]   redirect_pc_o;

  int                seed = 36;
  logic [ROB_W-1:0]  rob_cnt = '0;
  logic              issued_q = 1'b0;
  expect_t           exp_q [$];

  exec_top #(
    .HAS_ZBB  (TB_HAS_ZBB),
    .NUM_PREGS(TB_NUM_PREGS)
  ) dut_i (.*);

  always #(CLK_PERIOD / 2) core_clock_i = ~core_clock_i;

  function automatic logic [31:0] draw();
    return $unsigned($random(seed));
  endfunction

  function automatic logic [PREG_W-1:0] pick_tag();
    return PREG_W'(draw());
  endfunction

  // never tag 0
  function automatic logic [PREG_W-1:0] pick_dest();
    return PREG_W'(draw() % 32'd63) + PREG_W'(1);
  endfunction

  task automatic report_error(input string what);
    $display("%s", what);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [XLEN-1:0] want,
                                 input logic [XLEN-1:0] got);
    report_error($sformatf("FAIL time %0t: %s expected %h got %h", $time, name, want, got));
  endtask

  task automatic check_result(input logic [ROB_W-1:0] rob, input logic [PREG_W-1:0] dest,
                              input logic [XLEN-1:0] data);
    if (result_rob_o !== rob) begin
      report_mismatch("result_rob_o", XLEN'(rob), XLEN'(result_rob_o));
    end
    if (result_dest_o !== dest) begin
      report_mismatch("result_dest_o", XLEN'(dest), XLEN'(result_dest_o));
    end
    if (result_data_o !== data) begin
      report_mismatch("result_data_o", data, result_data_o);
    end
  endtask

  task automatic check_redirect(input logic valid, input logic [PC_W-1:0] pc);
    if (redirect_valid_o !== valid) begin
      report_mismatch("redirect_valid_o", XLEN'(valid), XLEN'(redirect_valid_o));
    end
    // pc only matters with a redirect
    if (valid && (redirect_pc_o !== pc)) begin
      report_mismatch("redirect_pc_o", XLEN'(pc), XLEN'(redirect_pc_o));
    end
  endtask

  // drive one micro-op, queue its expected result
  task automatic issue_uop(input uop_class_e cls, input alu_op_e op, input br_cond_e cond,
                           input logic [PREG_W-1:0] rs1, input logic [PREG_W-1:0] rs2,
                           input logic [PREG_W-1:0] dest, input logic use_imm,
                           input logic [XLEN-1:0] imm, input logic [PC_W-1:0] pc,
                           input logic ptaken, input logic [PC_W-1:0] ptarget);
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic            taken;
    logic [PC_W:0]   redir;
    expect_t         want;
    // operand rules, shadow already holds every older result
    if (cls == CLS_LUI) begin
      a = '0;
    end else if ((cls == CLS_AUIPC) || (cls == CLS_JAL)) begin
      a = {pc, 2'b00};
    end else begin
      a = shadow_regs[rs1];
    end
    b = (use_imm || (cls == CLS_LUI) || (cls == CLS_AUIPC)) ? imm : shadow_regs[rs2];
    taken = ref_branch(cls, cond, a, b);
    redir = ref_redirect(cls, taken, ref_target(cls, a, imm, pc), pc, ptaken, ptarget);
    want.rob      = rob_cnt;
    want.dest     = dest;
    want.redir    = redir[PC_W];
    want.redir_pc = redir[PC_W-1:0];
    if ((cls == CLS_JAL) || (cls == CLS_JALR)) begin
      want.data = {pc + PC_W'(1), 2'b00};
    end else if ((cls == CLS_LUI) || (cls == CLS_AUIPC)) begin
      want.data = a + b;
    end else begin
      want.data = ref_alu(op, a, b);
    end
    @(posedge core_clock_i);
    issue_valid_i   <= 1'b1;
    issue_rs1_i     <= rs1;
    issue_rs2_i     <= rs2;
    issue_dest_i    <= dest;
    issue_rob_i     <= rob_cnt;
    issue_class_i   <= cls;
    issue_alu_op_i  <= op;
    issue_cond_i    <= cond;
    issue_use_imm_i <= use_imm;
    issue_imm_i     <= imm;
    issue_pc_i      <= pc;
    pred_taken_i    <= ptaken;
    pred_target_i   <= ptarget;
    exp_q.push_back(want);
    rob_cnt = rob_cnt + ROB_W'(1);
    if ((cls != CLS_BRANCH) && (dest != '0)) begin
      shadow_regs[dest] = want.data;
    end
  endtask

  // mode 0 right guess, 1 wrong direction, 2 taken with wrong target
  task automatic send_predicted(input uop_class_e cls, input alu_op_e op, input br_cond_e cond,
                                input logic [PREG_W-1:0] rs1, input logic [PREG_W-1:0] rs2,
                                input logic [PREG_W-1:0] dest, input logic use_imm,
                                input logic [XLEN-1:0] imm, input logic [PC_W-1:0] pc,
                                input int mode);
    logic            taken;
    logic [PC_W-1:0] target;
    taken  = ref_branch(cls, cond, shadow_regs[rs1], use_imm ? imm : shadow_regs[rs2]);
    target = ref_target(cls, shadow_regs[rs1], imm, pc);
    if (mode == 0) begin
      issue_uop(cls, op, cond, rs1, rs2, dest, use_imm, imm, pc, taken, target);
    end else if (mode == 1) begin
      issue_uop(cls, op, cond, rs1, rs2, dest, use_imm, imm, pc, !taken, target);
    end else begin
      issue_uop(cls, op, cond, rs1, rs2, dest, use_imm, imm, pc, 1'b1, target ^ PC_W'(5));
    end
  endtask

  task automatic idle_cycle();
    @(posedge core_clock_i);
    issue_valid_i <= 1'b0;
  endtask

  // completion due one cycle after each issue
  always @(posedge core_clock_i) begin
    issued_q <= issue_valid_i;
  end

  // outputs settled by the falling edge
  always @(negedge core_clock_i) begin : compare
    expect_t want;
    if (result_valid_o !== issued_q) begin
      report_mismatch("result_valid_o", XLEN'(issued_q), XLEN'(result_valid_o));
    end
    if (issued_q) begin
      if (exp_q.size() == 0) begin
        report_error("a completion arrived with no micro-op outstanding");
      end
      want = exp_q.pop_front();
      check_result(want.rob, want.dest, want.data);
      check_redirect(want.redir, want.redir_pc);
    end else begin
      check_redirect(1'b0, '0);
    end
  end

  initial begin
    #((TOTAL_UOPS + 40) * CLK_PERIOD);
    report_error("timeout, the test did not reach its end");
  end

  initial begin
    logic [PREG_W-1:0] rs1;
    logic [PREG_W-1:0] rs2;
    logic [PREG_W-1:0] dest;
    logic [PREG_W-1:0] prev;
    uop_class_e        cls;
    logic [31:0]       rnd;
    rst_n_i         = 1'b0;
    issue_valid_i   = 1'b0;
    issue_rs1_i     = '0;
    issue_rs2_i     = '0;
    issue_dest_i    = '0;
    issue_rob_i     = '0;
    issue_class_i   = CLS_ALU;
    issue_alu_op_i  = ALU_ADD;
    issue_cond_i    = BR_EQ;
    issue_use_imm_i = 1'b0;
    issue_imm_i     = '0;
    issue_pc_i      = '0;
    pred_taken_i    = 1'b0;
    pred_target_i   = '0;
    for (int t = 0; t < TB_NUM_PREGS; t++) begin
      shadow_regs[t] = '0;
    end
    repeat (RESET_CYCLES) @(posedge core_clock_i);
    rst_n_i <= 1'b1;
    // quiet outputs while idle
    repeat (4) idle_cycle();
    // every register reads zero after reset
    for (int t = 0; t < SWEEP_UOPS; t++) begin
      issue_uop(CLS_ALU, ALU_OR, BR_EQ, PREG_W'(t), PREG_W'(t), '0, 1'b0, '0, '0, 1'b0, '0);
    end
    // load random values everywhere
    for (int t = 1; t <= FILL_UOPS; t++) begin
      issue_uop(CLS_ALU, ALU_ADD, BR_EQ, '0, '0, PREG_W'(t), 1'b1, draw(), '0, 1'b0, '0);
    end
    // each op with register and immediate b
    for (int k = 0; k < ALU_UOPS / 2; k++) begin
      for (int u = 0; u < 2; u++) begin
        issue_uop(CLS_ALU, alu_op_e'(4'(k)), BR_EQ, pick_tag(), pick_tag(), pick_dest(),
                  u[0], draw(), '0, 1'b0, '0);
      end
    end
    // back-to-back dependency, alternating the read port
    prev = PREG_W'(5);
    for (int i = 0; i < CHAIN_UOPS; i++) begin
      dest = pick_dest();
      rs1  = i[0] ? prev : pick_tag();
      rs2  = i[0] ? pick_tag() : prev;
      issue_uop(CLS_ALU, alu_op_e'(4'(draw() % 32'd5)), BR_EQ, rs1, rs2, dest, 1'b0,
                '0, '0, 1'b0, '0);
      prev = dest;
    end
    // tag 0 write dropped, then read straight after
    issue_uop(CLS_ALU, ALU_ADD, BR_EQ, '0, '0, '0, 1'b1, 32'h1234_5678, '0, 1'b0, '0);
    issue_uop(CLS_ALU, ALU_OR, BR_EQ, '0, '0, PREG_W'(7), 1'b0, '0, '0, 1'b0, '0);
    issue_uop(CLS_LUI, ALU_SUB, BR_EQ, PREG_W'(3), '0, PREG_W'(8), 1'b0, 32'hABCD_E000,
              '0, 1'b0, '0);
    issue_uop(CLS_LUI, ALU_XOR, BR_EQ, '0, '0, '0, 1'b0, draw(), '0, 1'b0, '0);
    issue_uop(CLS_AUIPC, ALU_AND, BR_EQ, '0, '0, PREG_W'(9), 1'b0, 32'h0000_1000,
              PC_W'(draw()), 1'b0, '0);
    issue_uop(CLS_AUIPC, ALU_ADD, BR_EQ, PREG_W'(9), '0, PREG_W'(10), 1'b0, draw(),
              PC_W'(draw()), 1'b0, '0);
    // conditional branches against all three predictions
    for (int c = 0; c < 6; c++) begin
      for (int v = 0; v < 3; v++) begin
        rs1 = pick_tag();
        rs2 = (v == 0) ? rs1 : pick_tag();
        send_predicted(CLS_BRANCH, ALU_SUB, br_cond_e'(3'(c)), rs1, rs2, pick_dest(),
                       1'b0, draw(), PC_W'(draw()), v);
      end
    end
    for (int v = 0; v < 3; v++) begin
      send_predicted(CLS_JAL, ALU_ADD, BR_EQ, '0, '0, pick_dest(), 1'b0, draw(),
                     PC_W'(draw()), v);
      send_predicted(CLS_JALR, ALU_ADD, BR_EQ, pick_tag(), '0, pick_dest(), 1'b0, draw(),
                     PC_W'(draw()), v);
    end
    // mixed random stream, half the rs1 tags chained
    for (int i = 0; i < RANDOM_UOPS; i++) begin
      cls  = uop_class_e'(3'(draw() % 32'd6));
      rnd  = draw();
      rs1  = rnd[0] ? prev : pick_tag();
      dest = pick_dest();
      send_predicted(cls, alu_op_e'(4'(draw() % 32'd15)), br_cond_e'(3'(draw() % 32'd6)),
                     rs1, pick_tag(), dest, (cls != CLS_BRANCH) && rnd[1], draw(),
                     PC_W'(draw()), int'(draw() % 32'd3));
      prev = dest;
    end
    repeat (3) idle_cycle();
    if (exp_q.size() == 0) begin
      $display("Test passed");
      $finish;
    end else begin
      report_error($sformatf("%0d expected results never completed", exp_q.size()));
    end
  end

endmodule

// File: compile.f
+incdir+tests
verilog/exec_pkg.sv
verilog/phys_regfile.sv
verilog/operand_stage.sv
verilog/int_alu.sv
verilog/branch_resolve.sv
verilog/simple_pipe.sv
verilog/exec_top.sv
tests/tb_exec_top.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_exec_top
FILELIST = compile.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "Test passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
